//--- filelist.f
+incdir+design
design/align_cmd_pkg.sv
design/align_mem_pkg.sv
design/align_addr_decode.sv
design/align_row_access.sv
design/align_sram.sv
design/align_read_result.sv
design/align_mem_top.sv
sim/align_clk_gen.sv
sim/align_mem_tb.sv

//--- Bender.yml
package:
  name: align_mem

sources:
  - include_dirs:
      - design
    files:
      - design/align_cmd_pkg.sv
      - design/align_mem_pkg.sv
      - design/align_addr_decode.sv
      - design/align_row_access.sv
      - design/align_sram.sv
      - design/align_read_result.sv
      - design/align_mem_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/align_clk_gen.sv
      - sim/align_mem_tb.sv

//--- sim/align_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "align_consts.svh"

module align_mem_tb
  import align_mem_pkg::*;
;

  logic  clk;
  logic  rst;
  logic  read;
  logic  write;
  addr_t addr;
  word_t din;
  logic  err_inj;
  word_t dout;
  logic  serr;
  padr_t padr;
  logic  rd_vld;

  int errors;
  int checks;
  int cyc; // Counted on falling edges

  // Reference model
  word_t ref_mem     [`ALIGN_NUMADDR];
  logic  ref_inj     [`ALIGN_NUMADDR];
  logic  ref_written [`ALIGN_NUMADDR];
  addr_t written_q [$];

  // Reads in flight, oldest first
  word_t exp_data [$];
  logic  exp_serr [$];
  padr_t exp_padr [$];
  int    exp_cyc  [$];

  align_clk_gen u_clk_gen (
    .clk
  );

  align_mem_top u_align_mem_top (
    .clk, .rst, .read, .write, .addr, .din, .err_inj,
    .dout, .serr, .padr, .rd_vld
  );

  //////////////////////////////
  // Checking and ending
  //////////////////////////////

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Read results are compared in order as they come back
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (serr === 1'b1 && rd_vld !== 1'b1) begin
      errors++;
      $display("serr was high without rd_vld at %0t", $time);
    end
    if (rd_vld === 1'b1) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("rd_vld pulsed with no read outstanding at %0t", $time);
      end else begin
        check_val("dout", dout, exp_data.pop_front());
        check_val("serr", serr, exp_serr.pop_front());
        check_val("padr", padr, exp_padr.pop_front());
        check_val("rd_vld latency", cyc - exp_cyc.pop_front(), 2 + `ALIGN_SRAM_DELAY);
      end
    end
  end

  //////////////////////////////
  // Drivers
  //////////////////////////////

  task automatic drive_write(input addr_t a, input word_t d, input logic inj);
    @(posedge clk);
    write   <= 1'b1;
    read    <= 1'b0;
    addr    <= a;
    din     <= d;
    err_inj <= inj;
    ref_mem[a] = d;
    ref_inj[a] = inj;
    if (!ref_written[a]) begin
      ref_written[a] = 1'b1;
      written_q.push_back(a);
    end
  endtask

  task automatic drive_read(input addr_t a);
    @(posedge clk);
    read    <= 1'b1;
    write   <= 1'b0;
    err_inj <= 1'b0;
    addr    <= a;
    exp_data.push_back(ref_mem[a]);
    exp_serr.push_back(ref_inj[a]);
    exp_padr.push_back({2'(a % 4), 8'(a / 4)}); // Lane, then row
    exp_cyc.push_back(cyc + 1); // Falling edge of the read cycle
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      read    <= 1'b0;
      write   <= 1'b0;
      err_inj <= 1'b0;
    end
  endtask

  task automatic wait_reads_done();
    int n;
    idle_cycles(1);
    n = 0;
    while (exp_data.size() != 0 && n < 32) begin
      @(posedge clk);
      n++;
    end
    if (exp_data.size() != 0) begin
      errors++;
      $display("Timeout: %0d reads did not return within %0d cycles", exp_data.size(), n);
      end_run();
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic basic_write_read();
    @(negedge clk);
    check_val("rd_vld after reset", rd_vld, 0);
    check_val("serr after reset", serr, 0);
    drive_write(10'h123, 32'hdeadbeef, 1'b0);
    idle_cycles(2);
    drive_read(10'h123);
    wait_reads_done();
  endtask

  task automatic lane_mask_rewrite();
    addr_t base;
    base = 10'h100;
    for (int i = 0; i < 4; i++) begin
      drive_write(base + i, 32'h1111_0000 * (i + 1) + i, 1'b0);
    end
    drive_write(base + 2, 32'hcafe_f00d, 1'b0); // Other lanes must keep their data
    for (int i = 0; i < 4; i++) begin
      drive_read(base + i);
    end
    wait_reads_done();
  endtask

  task automatic consecutive_reads();
    for (int i = 0; i < 6; i++) begin
      drive_write(10'h200 + i * 37, 32'h5a5a_0000 ^ (i << 8), 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      drive_read(10'h200 + i * 37);
    end
    wait_reads_done();
  endtask

  task automatic parity_injection();
    for (int i = 0; i < 4; i++) begin
      drive_write(10'h2c4 + i, 32'h0bad_0000 | i, 1'b0);
    end
    drive_write(10'h2c5, 32'h0f0f_3c3c, 1'b1); // Lane 1 gets bad parity
    for (int i = 0; i < 4; i++) begin
      drive_read(10'h2c4 + i);
    end
    wait_reads_done();
    drive_write(10'h2c5, 32'h0f0f_3c3c, 1'b0);
    for (int i = 0; i < 4; i++) begin
      drive_read(10'h2c4 + i);
    end
    wait_reads_done();
  endtask

  task automatic random_traffic();
    addr_t a;
    for (int i = 0; i < 200; i++) begin
      if (($urandom % 2) == 0 || written_q.size() == 0) begin
        a = addr_t'($urandom % `ALIGN_NUMADDR);
        drive_write(a, word_t'($urandom), ($urandom % 8) == 0);
        if (($urandom % 4) == 0) begin
          drive_read(a); // Same address right after the write
        end
      end else begin
        a = written_q[$urandom % written_q.size()];
        drive_read(a);
      end
      idle_cycles($urandom % 3);
    end
    wait_reads_done();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h4d3ff644));
    errors  = 0;
    checks  = 0;
    cyc     = 0;
    rst     = 1'b1;
    read    = 1'b0;
    write   = 1'b0;
    addr    = '0;
    din     = '0;
    err_inj = 1'b0;
    for (int i = 0; i < `ALIGN_NUMADDR; i++) begin
      ref_written[i] = 1'b0;
      ref_inj[i]     = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    basic_write_read();
    lane_mask_rewrite();
    consecutive_reads();
    parity_injection();
    random_traffic();
    idle_cycles(4);
    end_run();
  end

endmodule

`default_nettype wire

//--- sim/align_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module align_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk; // 8 ns period

endmodule

`default_nettype wire

//--- design/align_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module align_mem_top
  import align_cmd_pkg::*;
  import align_mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  read,
  input  wire logic  write,
  input  wire addr_t addr,
  input  wire word_t din,
  input  wire logic  err_inj,
  output word_t      dout,
  output logic       serr,
  output padr_t      padr,
  output logic       rd_vld
);

  // Decode to execute
  op_e   op;
  wsel_t wsel;
  srow_t srow;
  word_t wword;
  logic  winj;

  // Execute to SRAM
  logic  mem_read;
  logic  mem_write;
  srow_t mem_addr;
  row_t  mem_bw;
  row_t  mem_din;
  row_t  mem_dout;

  // Execute to result
  wsel_t rsel;
  srow_t rrow;
  logic  rtag;

  align_addr_decode u_decode (
    .clk, .rst, .read, .write, .addr, .din, .err_inj,
    .op, .wsel, .srow, .wword, .winj
  );

  align_row_access u_row_access (
    .clk, .rst, .op, .wsel, .srow, .wword, .winj,
    .mem_read, .mem_write, .mem_addr, .mem_bw, .mem_din,
    .rsel, .rrow, .rtag
  );

  align_sram u_sram (
    .clk, .mem_read, .mem_write, .mem_addr, .mem_bw, .mem_din, .mem_dout
  );

  align_read_result u_read_result (
    .clk, .rst, .mem_dout, .rsel, .rrow, .rtag,
    .dout, .serr, .padr, .rd_vld
  );

endmodule

`default_nettype wire

//--- design/align_read_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "align_consts.svh"

module align_read_result
  import align_mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire row_t  mem_dout,
  input  wire wsel_t rsel,
  input  wire srow_t rrow,
  input  wire logic  rtag,
  output word_t      dout,
  output logic       serr,
  output padr_t      padr,
  output logic       rd_vld
);

  mword_t lane;
  word_t  lane_data;
  logic   lane_perr;

  // Pull the addressed word down to bit 0
  assign lane      = mword_t'(mem_dout >> (rsel * `ALIGN_MEMWDTH));
  assign lane_data = lane[`ALIGN_WIDTH-1:0];
  assign lane_perr = (`ALIGN_PARITY != 0) && (^lane); // Even parity over data and parity bit

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
      serr   <= 1'b0;
    end else begin
      rd_vld <= rtag;
      serr   <= rtag && lane_perr;
    end
  end

  always_ff @(posedge clk) begin
    if (rtag) begin
      dout <= lane_data;
      padr <= {rsel, rrow};
    end
  end

endmodule

`default_nettype wire

//--- design/align_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "align_consts.svh"

module align_sram
  import align_mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  mem_read,
  input  wire logic  mem_write,
  input  wire srow_t mem_addr,
  input  wire row_t  mem_bw,
  input  wire row_t  mem_din,
  output row_t       mem_dout
);

  row_t mem_array [`ALIGN_NUMSROW];
  row_t rd_pipe   [`ALIGN_SRAM_DELAY];

  // Bit masked write
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem_array[mem_addr] <= (mem_din & mem_bw) | (mem_array[mem_addr] & ~mem_bw);
    end
  end

  always_ff @(posedge clk) begin
    if (mem_read) begin
      rd_pipe[0] <= mem_array[mem_addr];
    end
    for (int i = 1; i < `ALIGN_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign mem_dout = rd_pipe[`ALIGN_SRAM_DELAY-1];

  //////////////////////////////
  // Port usage
  //////////////////////////////

  ast_one_port: assert property (@(posedge clk)
    mem_read |-> !mem_write);

endmodule

`default_nettype wire

//--- design/align_row_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "align_consts.svh"

module align_row_access
  import align_cmd_pkg::*;
  import align_mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire op_e   op,
  input  wire wsel_t wsel,
  input  wire srow_t srow,
  input  wire word_t wword,
  input  wire logic  winj,
  output logic       mem_read,
  output logic       mem_write,
  output srow_t      mem_addr,
  output row_t       mem_bw,
  output row_t       mem_din,
  output wsel_t      rsel,
  output srow_t      rrow,
  output logic       rtag
);

  logic   wpar;
  mword_t sword;

  // Read tracking, one slot per SRAM delay stage
  logic [`ALIGN_SRAM_DELAY-1:0] tag_pipe;
  wsel_t                        sel_pipe [`ALIGN_SRAM_DELAY];
  srow_t                        row_pipe [`ALIGN_SRAM_DELAY];

  //////////////////////////////
  // SRAM request
  //////////////////////////////

  assign wpar  = (^wword) ^ winj;          // Inverted for fault injection
  assign sword = mword_t'({wpar, wword});  // Drops parity when not stored

  assign mem_read  = (op == OP_READ);
  assign mem_write = (op == OP_WRITE);
  assign mem_addr  = srow;

  // Only the addressed lane is enabled, the rest of the row is untouched
  assign mem_din = row_t'(sword) << (wsel * `ALIGN_MEMWDTH);
  assign mem_bw  = row_t'({`ALIGN_MEMWDTH{1'b1}}) << (wsel * `ALIGN_MEMWDTH);

  //////////////////////////////
  // Reads in flight
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_pipe <= '0;
    end else begin
      tag_pipe[0] <= mem_read;
      for (int i = 1; i < `ALIGN_SRAM_DELAY; i++) begin
        tag_pipe[i] <= tag_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    sel_pipe[0] <= wsel;
    row_pipe[0] <= srow;
    for (int i = 1; i < `ALIGN_SRAM_DELAY; i++) begin
      sel_pipe[i] <= sel_pipe[i-1];
      row_pipe[i] <= row_pipe[i-1];
    end
  end

  assign rsel = sel_pipe[`ALIGN_SRAM_DELAY-1];
  assign rrow = row_pipe[`ALIGN_SRAM_DELAY-1];
  assign rtag = tag_pipe[`ALIGN_SRAM_DELAY-1]; // Lines up with mem_dout

endmodule

`default_nettype wire

//--- design/align_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "align_consts.svh"

module align_addr_decode
  import align_cmd_pkg::*;
  import align_mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  read,
  input  wire logic  write,
  input  wire addr_t addr,
  input  wire word_t din,
  input  wire logic  err_inj,
  output op_e        op,
  output wsel_t      wsel,
  output srow_t      srow,
  output word_t      wword,
  output logic       winj
);

  op_e   op_nxt;
  wsel_t wsel_nxt;
  srow_t srow_nxt;

  assign op_nxt = read  ? OP_READ  :
                  write ? OP_WRITE : OP_IDLE;

  // Arithmetic split so a non power of two word count still packs densely
  assign wsel_nxt = wsel_t'(addr % `ALIGN_NUMWRDS);
  assign srow_nxt = srow_t'(addr / `ALIGN_NUMWRDS);

  always_ff @(posedge clk) begin
    if (rst) begin
      op <= OP_IDLE;
    end else begin
      op <= op_nxt;
    end
  end

  always_ff @(posedge clk) begin
    wsel  <= wsel_nxt;
    srow  <= srow_nxt;
    wword <= din;
    winj  <= write & err_inj; // Only meaningful on writes
  end

  //////////////////////////////
  // Request checks
  //////////////////////////////

  ast_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    read |-> !write);

endmodule

`default_nettype wire

//--- design/align_mem_pkg.sv
`default_nettype none

`include "align_consts.svh"

// Data and address types of the packed memory
package align_mem_pkg;

  //////////////////////////////
  // Data
  //////////////////////////////

  typedef logic [`ALIGN_WIDTH-1:0]                  word_t;  // Logical word
  typedef logic [`ALIGN_MEMWDTH-1:0]                mword_t; // Word plus parity
  typedef logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0] row_t;   // Row data or bit mask

  //////////////////////////////
  // Addressing
  //////////////////////////////

  typedef logic [`ALIGN_BITSROW-1:0]                srow_t;
  typedef logic [`ALIGN_BITWRDS-1:0]                wsel_t;
  typedef logic [`ALIGN_BITADDR-1:0]                addr_t;
  typedef logic [`ALIGN_BITWRDS+`ALIGN_BITSROW-1:0] padr_t;  // {wsel, row}

endpackage

`default_nettype wire

//--- design/align_cmd_pkg.sv
`default_nettype none

// Access opcodes carried from decode into the execute stage
package align_cmd_pkg;

  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } op_e;

endpackage

`default_nettype wire

//--- design/align_consts.svh
`ifndef ALIGN_CONSTS_SVH
`define ALIGN_CONSTS_SVH

//////////////////////////////
// Logical word
//////////////////////////////

`define ALIGN_WIDTH      32                             // Data bits per word
`define ALIGN_PARITY     1                              // Even parity bit stored
`define ALIGN_MEMWDTH    (`ALIGN_WIDTH + `ALIGN_PARITY) // Stored bits per word

//////////////////////////////
// Address space and layout
//////////////////////////////

`define ALIGN_NUMADDR    1024 // Logical words
`define ALIGN_BITADDR    10
`define ALIGN_NUMWRDS    4    // Words packed into one row
`define ALIGN_BITWRDS    2
`define ALIGN_NUMSROW    256  // SRAM rows
`define ALIGN_BITSROW    8

`define ALIGN_SRAM_DELAY 2    // Read latency in cycles

`endif
